/* sources.f */
+incdir+tests
hw/cpu_isa_pkg.sv
hw/cpu_pipe_pkg.sv
hw/fetch_unit.sv
hw/pipeline_control.sv
hw/register_file.sv
hw/execute_unit.sv
hw/memory_stage.sv
hw/cpu_core.sv
tests/tb_cpu_core.sv

/* Makefile */
SIM        ?= verilator
TOP        ?= tb_cpu_core
FILELIST   ?= sources.f
MDIR       ?= obj_dir
FLAGS      ?= --binary --timing -Wno-fatal --Mdir $(MDIR)
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	@out=$$(./$(MDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(MDIR)

/* tests/cpu_tests.svh */
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

//////////////////////////////
// ALU and ADDI
//////////////////////////////

task automatic test_alu_addi();
  prog.delete();
  for (int r = 1; r <= 4; r++) begin
    prog.push_back(itype_word(OP_ADDI, 5'(r), 5'd0, random_imm()));
  end
  prog.push_back(rtype_word(OP_ADD, 5'd5, 5'd1, 5'd2));
  prog.push_back(rtype_word(OP_SUB, 5'd6, 5'd1, 5'd2));
  prog.push_back(rtype_word(OP_AND, 5'd7, 5'd3, 5'd4));
  prog.push_back(rtype_word(OP_OR, 5'd8, 5'd3, 5'd4));
  prog.push_back(rtype_word(OP_SLT, 5'd9, 5'd1, 5'd2));
  prog.push_back(rtype_word(OP_SLT, 5'd10, 5'd2, 5'd1));
  // signed compare against a possibly negative difference
  prog.push_back(rtype_word(OP_SLT, 5'd11, 5'd6, 5'd0));
  prog.push_back(rtype_word(OP_SLT, 5'd12, 5'd0, 5'd6));
  append_halt();
  run_program("alu_addi");
endtask

//////////////////////////////
// forwarding
//////////////////////////////

task automatic test_forwarding();
  prog.delete();
  prog.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, random_imm()));
  prog.push_back(rtype_word(OP_ADD, 5'd2, 5'd1, 5'd1));
  prog.push_back(rtype_word(OP_ADD, 5'd3, 5'd2, 5'd1));
  prog.push_back(rtype_word(OP_SUB, 5'd4, 5'd3, 5'd2));
  prog.push_back(rtype_word(OP_OR, 5'd5, 5'd4, 5'd3));
  prog.push_back(rtype_word(OP_AND, 5'd6, 5'd5, 5'd1));
  prog.push_back(itype_word(OP_ADDI, 5'd6, 5'd6, random_imm()));
  prog.push_back(rtype_word(OP_SLT, 5'd7, 5'd6, 5'd5));
  prog.push_back(rtype_word(OP_ADD, 5'd8, 5'd7, 5'd6));
  prog.push_back(rtype_word(OP_ADD, 5'd9, 5'd8, 5'd8));
  append_halt();
  run_program("forwarding");
endtask

//////////////////////////////
// load-use
//////////////////////////////

task automatic test_load_use();
  prog.delete();
  prog.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, random_imm()));
  prog.push_back(itype_word(OP_ADDI, 5'd2, 5'd0, 16'd16));
  prog.push_back(itype_word(OP_SW, 5'd1, 5'd2, 16'd4));
  prog.push_back(itype_word(OP_LW, 5'd3, 5'd2, 16'd4));
  prog.push_back(rtype_word(OP_ADD, 5'd4, 5'd3, 5'd1));
  prog.push_back(itype_word(OP_LW, 5'd5, 5'd2, 16'd4));
  prog.push_back(rtype_word(OP_SUB, 5'd6, 5'd1, 5'd5));
  // loaded word stored straight back
  prog.push_back(itype_word(OP_LW, 5'd7, 5'd2, 16'd4));
  prog.push_back(itype_word(OP_SW, 5'd7, 5'd2, 16'd5));
  prog.push_back(itype_word(OP_LW, 5'd8, 5'd2, 16'd5));
  prog.push_back(itype_word(OP_ADDI, 5'd9, 5'd8, 16'd1));
  prog.push_back(itype_word(OP_LW, 5'd10, 5'd2, 16'd4));
  prog.push_back(32'h0);
  prog.push_back(rtype_word(OP_ADD, 5'd11, 5'd10, 5'd10));
  append_halt();
  run_program("load_use");
endtask

//////////////////////////////
// branches and jump
//////////////////////////////

task automatic test_branches();
  prog.delete();
  prog.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, 16'd7));
  prog.push_back(itype_word(OP_ADDI, 5'd2, 5'd0, 16'd7));
  prog.push_back(branch_word(OP_BEQ, 5'd1, 5'd2, 16'd5));
  prog.push_back(itype_word(OP_ADDI, 5'd3, 5'd0, 16'd111));
  prog.push_back(itype_word(OP_ADDI, 5'd3, 5'd0, 16'd222));
  prog.push_back(itype_word(OP_ADDI, 5'd4, 5'd0, 16'd3));
  prog.push_back(branch_word(OP_BEQ, 5'd1, 5'd4, 16'd9));
  prog.push_back(itype_word(OP_ADDI, 5'd5, 5'd0, 16'd55));
  prog.push_back(branch_word(OP_BLT, 5'd4, 5'd1, 16'd11));
  prog.push_back(itype_word(OP_ADDI, 5'd6, 5'd0, 16'd66));
  prog.push_back(itype_word(OP_ADDI, 5'd6, 5'd0, 16'd67));
  prog.push_back(branch_word(OP_BLT, 5'd1, 5'd4, 16'd14));
  prog.push_back(itype_word(OP_ADDI, 5'd7, 5'd0, 16'd77));
  prog.push_back(jump_word(16'd16));
  prog.push_back(itype_word(OP_ADDI, 5'd8, 5'd0, 16'd88));
  prog.push_back(itype_word(OP_ADDI, 5'd8, 5'd0, 16'd89));
  // negative operand, taken only as a signed compare
  prog.push_back(rtype_word(OP_SUB, 5'd10, 5'd4, 5'd1));
  prog.push_back(branch_word(OP_BLT, 5'd10, 5'd0, 16'd20));
  prog.push_back(itype_word(OP_ADDI, 5'd11, 5'd0, 16'd1));
  prog.push_back(itype_word(OP_ADDI, 5'd11, 5'd0, 16'd2));
  prog.push_back(rtype_word(OP_ADD, 5'd9, 5'd5, 5'd7));
  append_halt();
  run_program("branches");
endtask

//////////////////////////////
// register zero
//////////////////////////////

task automatic test_reg_zero();
  prog.delete();
  prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd0, 16'd123));
  prog.push_back(rtype_word(OP_ADD, 5'd1, 5'd0, 5'd0));
  prog.push_back(itype_word(OP_ADDI, 5'd2, 5'd0, 16'd9));
  prog.push_back(rtype_word(OP_ADD, 5'd0, 5'd2, 5'd2));
  prog.push_back(rtype_word(OP_ADD, 5'd3, 5'd0, 5'd2));
  prog.push_back(itype_word(OP_SW, 5'd2, 5'd0, 16'd32));
  prog.push_back(itype_word(OP_LW, 5'd0, 5'd0, 16'd32));
  prog.push_back(rtype_word(OP_ADD, 5'd4, 5'd0, 5'd2));
  prog.push_back(rtype_word(OP_OR, 5'd5, 5'd0, 5'd0));
  append_halt();
  run_program("reg_zero");
endtask

`endif

/* tests/tb_cpu_core.sv */
`timescale 1ns/100ps

module tb_cpu_core
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
();

  localparam int CLK_PERIOD       = 10;
  localparam int RESET_CYCLES     = 5;
  localparam int IMEM_ADDR_BITS   = 8;
  localparam int DMEM_ADDR_BITS   = 8;
  localparam int IMEM_DEPTH       = 2 ** IMEM_ADDR_BITS;
  localparam int DMEM_DEPTH       = 2 ** DMEM_ADDR_BITS;
  localparam int NUM_TESTS        = 5;
  localparam int CYCLES_PER_TEST  = 200;
  localparam int WATCHDOG_CYCLES  = NUM_TESTS * CYCLES_PER_TEST;
  localparam int RUN_TIMEOUT      = 150;
  localparam int DRAIN_CYCLES     = 10;
  localparam int MODEL_STEP_LIMIT = 200;

  logic        clk;
  logic        rst;
  imem_write_t imem_load;
  retire_t     wb;

  int     errors;
  int     checks;
  integer seed;

  // program image and writeback streams
  logic [31:0] prog [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  logic [4:0]  got_rd [$];
  logic [31:0] got_data [$];

  // reference model state
  logic [31:0] model_regs [32];
  logic [31:0] model_mem [DMEM_DEPTH];

  cpu_core #(
    .IMEM_ADDR_BITS (IMEM_ADDR_BITS),
    .DMEM_ADDR_BITS (DMEM_ADDR_BITS)
  ) i_dut (
    .clk       (clk),
    .rst       (rst),
    .imem_load (imem_load),
    .wb        (wb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  // wb is registered, so mid-cycle is a safe sample point
  always @(negedge clk) begin
    if (wb.valid) begin
      got_rd.push_back(wb.rd);
      got_data.push_back(wb.data);
    end
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [15:0] random_imm();
    return 16'($random(seed));
  endfunction

  //////////////////////////////
  // instruction encoding
  //////////////////////////////

  function automatic logic [31:0] rtype_word(input opcode_e op, input logic [4:0] rd,
                                             input logic [4:0] rs, input logic [4:0] rt);
    return {op, rs, rt, rd, 11'b0};
  endfunction

  function automatic logic [31:0] itype_word(input opcode_e op, input logic [4:0] rt,
                                             input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] branch_word(input opcode_e op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] target);
    return {op, rs, rt, target};
  endfunction

  function automatic logic [31:0] jump_word(input logic [15:0] target);
    return {OP_J, 10'b0, target};
  endfunction

  // a jump to itself ends every program
  task automatic append_halt();
    prog.push_back(jump_word(16'(prog.size())));
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  task automatic record_write(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0) begin
      model_regs[rd] = value;
      exp_rd.push_back(rd);
      exp_data.push_back(value);
    end
  endtask

  task automatic run_model();
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr_sum;
    opcode_e     op;
    int          pc;
    int          next_pc;
    int          target;
    int          steps;
    bit          halted;
    exp_rd.delete();
    exp_data.delete();
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    pc     = 0;
    steps  = 0;
    halted = 1'b0;
    while (!halted && steps < MODEL_STEP_LIMIT && pc < prog.size()) begin
      word     = prog[pc];
      op       = opcode_e'(word[31:26]);
      a        = model_regs[word[25:21]];
      b        = model_regs[word[20:16]];
      imm      = {16'b0, word[15:0]};
      addr_sum = a + imm;
      target   = int'(word[IMEM_ADDR_BITS-1:0]);
      next_pc  = (pc + 1) % IMEM_DEPTH;
      case (op)
        OP_ADD:  record_write(word[15:11], a + b);
        OP_SUB:  record_write(word[15:11], a - b);
        OP_AND:  record_write(word[15:11], a & b);
        OP_OR:   record_write(word[15:11], a | b);
        OP_SLT:  record_write(word[15:11], {31'b0, $signed(a) < $signed(b)});
        OP_ADDI: record_write(word[20:16], a + imm);
        OP_LW:   record_write(word[20:16], model_mem[addr_sum[DMEM_ADDR_BITS-1:0]]);
        OP_SW:   model_mem[addr_sum[DMEM_ADDR_BITS-1:0]] = b;
        OP_BEQ: begin
          if (a == b) next_pc = target;
        end
        OP_BLT: begin
          if ($signed(a) < $signed(b)) next_pc = target;
        end
        OP_J: begin
          halted  = (target == pc);
          next_pc = target;
        end
        default: ;
      endcase
      pc = next_pc;
      steps++;
    end
  endtask

  //////////////////////////////
  // program runner
  //////////////////////////////

  task automatic run_program(input string name);
    int cycles;
    int n;
    @(negedge clk);
    rst = 1'b1;
    // two nops behind the halt keep stale words out of the fetch path
    for (int i = 0; i < prog.size() + 2; i++) begin
      imem_load.we   = 1'b1;
      imem_load.addr = PC_BITS'(i);
      imem_load.data = (i < prog.size()) ? prog[i] : 32'h0;
      @(negedge clk);
    end
    imem_load = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    run_model();
    got_rd.delete();
    got_data.delete();
    rst    = 1'b0;
    cycles = 0;
    while (got_rd.size() < exp_rd.size() && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    repeat (DRAIN_CYCLES) @(negedge clk);
    if (got_rd.size() != exp_rd.size()) begin
      errors++;
      $display("%s: expected %0d register writes on the writeback port, saw %0d",
               name, exp_rd.size(), got_rd.size());
    end
    n = (got_rd.size() < exp_rd.size()) ? got_rd.size() : exp_rd.size();
    for (int i = 0; i < n; i++) begin
      check_value(64'(got_rd[i]), 64'(exp_rd[i]), $sformatf("%s write %0d register", name, i));
      check_value(64'(got_data[i]), 64'(exp_data[i]), $sformatf("%s write %0d data", name, i));
    end
  endtask

  `include "cpu_tests.svh"

  initial begin
    rst       = 1'b1;
    imem_load = '0;
    errors    = 0;
    checks    = 0;
    seed      = 70;
    test_alu_addi();
    test_forwarding();
    test_load_use();
    test_branches();
    test_reg_zero();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* hw/cpu_core.sv */
`timescale 1ns/100ps

module cpu_core
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
#(
  parameter int IMEM_ADDR_BITS = 8,
  parameter int DMEM_ADDR_BITS = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  imem_write_t imem_load,
  output retire_t     wb
);

  // stage registers
  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;

  // decode and hazard control
  ctrl_t    ctrl;
  logic     stall;
  logic     flush;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;

  logic [DATA_WIDTH-1:0]     rs_data;
  logic [DATA_WIDTH-1:0]     rt_data;
  logic [DATA_WIDTH-1:0]     wb_data;
  logic                      branch_taken;
  logic [IMEM_ADDR_BITS-1:0] branch_target;

  //////////////////////////////
  // front end
  //////////////////////////////

  fetch_unit #(
    .IMEM_ADDR_BITS (IMEM_ADDR_BITS)
  ) i_fetch (
    .clk           (clk),
    .rst           (rst),
    .imem_load     (imem_load),
    .stall         (stall),
    .flush         (flush),
    .branch_target (branch_target),
    .if_id         (if_id)
  );

  pipeline_control i_control (
    .clk          (clk),
    .rst          (rst),
    .if_id        (if_id),
    .id_ex        (id_ex),
    .ex_mem       (ex_mem),
    .mem_wb       (mem_wb),
    .branch_taken (branch_taken),
    .ctrl         (ctrl),
    .stall        (stall),
    .flush        (flush),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b)
  );

  register_file i_regfile (
    .clk     (clk),
    .rst     (rst),
    .rs      (if_id.instr.rs),
    .rt      (if_id.instr.rt),
    .wb      (wb),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  //////////////////////////////
  // back end
  //////////////////////////////

  execute_unit #(
    .IMEM_ADDR_BITS (IMEM_ADDR_BITS)
  ) i_execute (
    .clk           (clk),
    .rst           (rst),
    .if_id         (if_id),
    .ctrl          (ctrl),
    .rs_data       (rs_data),
    .rt_data       (rt_data),
    .stall         (stall),
    .flush         (flush),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b),
    .wb_data       (wb_data),
    .id_ex         (id_ex),
    .ex_mem        (ex_mem),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  memory_stage #(
    .DMEM_ADDR_BITS (DMEM_ADDR_BITS)
  ) i_memory (
    .clk     (clk),
    .rst     (rst),
    .ex_mem  (ex_mem),
    .mem_wb  (mem_wb),
    .wb      (wb),
    .wb_data (wb_data)
  );

endmodule

/* hw/memory_stage.sv */
`timescale 1ns/100ps

module memory_stage
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
#(
  parameter int DMEM_ADDR_BITS = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  ex_mem_t               ex_mem,
  output mem_wb_t               mem_wb,
  output retire_t               wb,
  output logic [DATA_WIDTH-1:0] wb_data
);

  localparam int DMEM_DEPTH = 2 ** DMEM_ADDR_BITS;

  logic [DATA_WIDTH-1:0]     dmem [DMEM_DEPTH];
  logic [DMEM_ADDR_BITS-1:0] dmem_addr;
  logic [DATA_WIDTH-1:0]     load_word;

  //////////////////////////////
  // data memory
  //////////////////////////////

  // word address from the low bits of the ALU result
  assign dmem_addr = DMEM_ADDR_BITS'(ex_mem.alu_result);
  assign load_word = dmem[dmem_addr];

  always_ff @(posedge clk) begin
    if (ex_mem.mem_write) begin
      dmem[dmem_addr] <= ex_mem.store_data;
    end
  end

  //////////////////////////////
  // MEM/WB and writeback
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb <= '0;
    end else begin
      mem_wb.reg_write  <= ex_mem.reg_write;
      mem_wb.mem_read   <= ex_mem.mem_read;
      mem_wb.alu_result <= ex_mem.alu_result;
      mem_wb.load_data  <= load_word;
      mem_wb.rd         <= ex_mem.rd;
    end
  end

  assign wb_data = mem_wb.mem_read ? mem_wb.load_data : mem_wb.alu_result;

  // writes to r0 are dropped here
  assign wb.valid = mem_wb.reg_write && (mem_wb.rd != '0);
  assign wb.rd    = mem_wb.rd;
  assign wb.data  = wb_data;

endmodule

/* hw/execute_unit.sv */
`timescale 1ns/100ps

module execute_unit
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
#(
  parameter int IMEM_ADDR_BITS = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  if_id_t                    if_id,
  input  ctrl_t                     ctrl,
  input  logic [DATA_WIDTH-1:0]     rs_data,
  input  logic [DATA_WIDTH-1:0]     rt_data,
  input  logic                      stall,
  input  logic                      flush,
  input  fwd_sel_e                  fwd_a,
  input  fwd_sel_e                  fwd_b,
  input  logic [DATA_WIDTH-1:0]     wb_data,
  output id_ex_t                    id_ex,
  output ex_mem_t                   ex_mem,
  output logic                      branch_taken,
  output logic [IMEM_ADDR_BITS-1:0] branch_target
);

  logic [DATA_WIDTH-1:0] op_a;
  logic [DATA_WIDTH-1:0] op_b;
  logic [DATA_WIDTH-1:0] alu_b;
  logic [DATA_WIDTH-1:0] alu_result;
  logic                  zero;
  logic                  less;

  function automatic logic [DATA_WIDTH-1:0] pick_operand(
    input fwd_sel_e              sel,
    input logic [DATA_WIDTH-1:0] reg_val,
    input logic [DATA_WIDTH-1:0] ex_mem_val,
    input logic [DATA_WIDTH-1:0] mem_wb_val
  );
    case (sel)
      FWD_EX_MEM: return ex_mem_val;
      FWD_MEM_WB: return mem_wb_val;
      default:    return reg_val;
    endcase
  endfunction

  //////////////////////////////
  // ID/EX
  //////////////////////////////

  // bubble on load-use, squash on taken branch
  always_ff @(posedge clk) begin
    if (rst || stall || flush) begin
      id_ex <= '0;
    end else begin
      id_ex.ctrl    <= ctrl;
      id_ex.rs_data <= rs_data;
      id_ex.rt_data <= rt_data;
      id_ex.rs      <= if_id.instr.rs;
      id_ex.rt      <= if_id.instr.rt;
      id_ex.rd      <= ctrl.reg_dst_rd ? if_id.instr.rd : if_id.instr.rt;
      id_ex.imm     <= instr_imm(if_id.instr);
    end
  end

  //////////////////////////////
  // operands and ALU
  //////////////////////////////

  assign op_a  = pick_operand(fwd_a, id_ex.rs_data, ex_mem.alu_result, wb_data);
  assign op_b  = pick_operand(fwd_b, id_ex.rt_data, ex_mem.alu_result, wb_data);
  assign alu_b = id_ex.ctrl.alu_src_imm ? DATA_WIDTH'(id_ex.imm) : op_b;

  assign less = $signed(op_a) < $signed(alu_b);

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_ADD: alu_result = op_a + alu_b;
      ALU_SUB: alu_result = op_a - alu_b;
      ALU_AND: alu_result = op_a & alu_b;
      ALU_OR:  alu_result = op_a | alu_b;
      ALU_SLT: alu_result = DATA_WIDTH'(less);
      default: alu_result = op_a + alu_b;
    endcase
  end

  assign zero = (alu_result == '0);

  // absolute word target from the immediate
  assign branch_taken  = (id_ex.ctrl.branch_eq && zero) ||
                         (id_ex.ctrl.branch_lt && less) ||
                         id_ex.ctrl.jump;
  assign branch_target = IMEM_ADDR_BITS'(id_ex.imm);

  //////////////////////////////
  // EX/MEM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem <= '0;
    end else begin
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= op_b;
      ex_mem.rd         <= id_ex.rd;
    end
  end

endmodule

/* hw/register_file.sv */
`timescale 1ns/100ps

module register_file
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [REG_ADDR_BITS-1:0] rs,
  input  logic [REG_ADDR_BITS-1:0] rt,
  input  retire_t                  wb,
  output logic [DATA_WIDTH-1:0]    rs_data,
  output logic [DATA_WIDTH-1:0]    rt_data
);

  localparam int NUM_REGS = 2 ** REG_ADDR_BITS;

  logic [DATA_WIDTH-1:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // r0 reads zero, same-cycle write passes straight through
  assign rs_data = (rs == '0)                  ? '0      :
                   (wb.valid && wb.rd == rs)   ? wb.data :
                                                 regs[rs];

  assign rt_data = (rt == '0)                  ? '0      :
                   (wb.valid && wb.rd == rt)   ? wb.data :
                                                 regs[rt];

endmodule

/* hw/pipeline_control.sv */
`timescale 1ns/100ps

module pipeline_control
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  if_id_t   if_id,
  input  id_ex_t   id_ex,
  input  ex_mem_t  ex_mem,
  input  mem_wb_t  mem_wb,
  input  logic     branch_taken,
  output ctrl_t    ctrl,
  output logic     stall,
  output logic     flush,
  output fwd_sel_e fwd_a,
  output fwd_sel_e fwd_b
);

  logic stall_release;
  logic uses_rs;
  logic uses_rt;
  logic load_use;

  // EX/MEM beats MEM/WB, loads in EX/MEM are covered by the stall
  function automatic fwd_sel_e pick_source(
    input logic [REG_ADDR_BITS-1:0] src,
    input ex_mem_t                  em,
    input mem_wb_t                  mw
  );
    if (src == '0) begin
      return FWD_REG;
    end
    if (em.reg_write && em.rd == src) begin
      return em.mem_read ? FWD_REG : FWD_EX_MEM;
    end
    if (mw.reg_write && mw.rd == src) begin
      return FWD_MEM_WB;
    end
    return FWD_REG;
  endfunction

  //////////////////////////////
  // decode
  //////////////////////////////

  always_comb begin
    ctrl = '0;
    case (if_id.instr.opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT: begin
        ctrl.reg_dst_rd = 1'b1;
        ctrl.reg_write  = 1'b1;
        case (if_id.instr.opcode)
          OP_SUB:  ctrl.alu_op = ALU_SUB;
          OP_AND:  ctrl.alu_op = ALU_AND;
          OP_OR:   ctrl.alu_op = ALU_OR;
          OP_SLT:  ctrl.alu_op = ALU_SLT;
          default: ctrl.alu_op = ALU_ADD;
        endcase
      end
      OP_ADDI: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
      end
      OP_LW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
      end
      OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      OP_BEQ: begin
        ctrl.alu_op    = ALU_SUB;
        ctrl.branch_eq = 1'b1;
      end
      OP_BLT: begin
        ctrl.alu_op    = ALU_SUB;
        ctrl.branch_lt = 1'b1;
      end
      OP_J:    ctrl.jump = 1'b1;
      default: ctrl = '0;
    endcase
  end

  //////////////////////////////
  // hazards
  //////////////////////////////

  // rt is a source for R-type, stores and branches
  assign uses_rs = !ctrl.jump;
  assign uses_rt = (!ctrl.alu_src_imm || ctrl.mem_write) && !ctrl.jump;

  assign load_use = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                    ((uses_rs && id_ex.rd == if_id.instr.rs) ||
                     (uses_rt && id_ex.rd == if_id.instr.rt));

  assign stall = load_use && !stall_release && !branch_taken;
  assign flush = branch_taken;

  // set for the cycle after a bubble went in
  always_ff @(posedge clk) begin
    if (rst) begin
      stall_release <= 1'b0;
    end else begin
      stall_release <= stall;
    end
  end

  assign fwd_a = pick_source(id_ex.rs, ex_mem, mem_wb);
  assign fwd_b = pick_source(id_ex.rt, ex_mem, mem_wb);

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit
  import cpu_isa_pkg::*, cpu_pipe_pkg::*;
#(
  parameter int IMEM_ADDR_BITS = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  imem_write_t               imem_load,
  input  logic                      stall,
  input  logic                      flush,
  input  logic [IMEM_ADDR_BITS-1:0] branch_target,
  output if_id_t                    if_id
);

  localparam int IMEM_DEPTH = 2 ** IMEM_ADDR_BITS;

  instr_t                    imem [IMEM_DEPTH];
  logic [IMEM_ADDR_BITS-1:0] pc;
  logic [IMEM_ADDR_BITS-1:0] load_addr;
  instr_t                    fetched;

  //////////////////////////////
  // instruction memory
  //////////////////////////////

  assign load_addr = IMEM_ADDR_BITS'(imem_load.addr);

  always_ff @(posedge clk) begin
    if (imem_load.we) begin
      imem[load_addr] <= imem_load.data;
    end
  end

  // word addressed, async read
  assign fetched = imem[pc];

  //////////////////////////////
  // pc and IF/ID
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (flush) begin
      pc <= branch_target;
    end else if (!stall) begin
      pc <= pc + 1'b1;
    end
  end

  // flush wins over stall, the held instruction is squashed anyway
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      if_id <= '0;
    end else if (!stall) begin
      if_id.pc    <= PC_BITS'(pc);
      if_id.instr <= fetched;
    end
  end

endmodule

/* hw/cpu_pipe_pkg.sv */
package cpu_pipe_pkg;

  import cpu_isa_pkg::*;

  // pc and branch targets come from the immediate field
  localparam int PC_BITS = IMM_BITS;

  //////////////////////////////
  // control and forwarding
  //////////////////////////////

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    reg_dst_rd;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch_eq;
    logic    branch_lt;
    logic    jump;
  } ctrl_t;

  typedef enum logic [1:0] {
    FWD_REG    = 2'd0,
    FWD_EX_MEM = 2'd1,
    FWD_MEM_WB = 2'd2
  } fwd_sel_e;

  //////////////////////////////
  // stage registers
  //////////////////////////////

  typedef struct packed {
    logic [PC_BITS-1:0] pc;
    instr_t             instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t                    ctrl;
    logic [DATA_WIDTH-1:0]    rs_data;
    logic [DATA_WIDTH-1:0]    rt_data;
    logic [REG_ADDR_BITS-1:0] rs;
    logic [REG_ADDR_BITS-1:0] rt;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [IMM_BITS-1:0]      imm;
  } id_ex_t;

  typedef struct packed {
    logic                     reg_write;
    logic                     mem_read;
    logic                     mem_write;
    logic [DATA_WIDTH-1:0]    alu_result;
    logic [DATA_WIDTH-1:0]    store_data;
    logic [REG_ADDR_BITS-1:0] rd;
  } ex_mem_t;

  typedef struct packed {
    logic                     reg_write;
    logic                     mem_read;
    logic [DATA_WIDTH-1:0]    alu_result;
    logic [DATA_WIDTH-1:0]    load_data;
    logic [REG_ADDR_BITS-1:0] rd;
  } mem_wb_t;

  //////////////////////////////
  // external ports
  //////////////////////////////

  // one register write per valid cycle
  typedef struct packed {
    logic                     valid;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [DATA_WIDTH-1:0]    data;
  } retire_t;

  typedef struct packed {
    logic               we;
    logic [PC_BITS-1:0] addr;
    instr_t             data;
  } imem_write_t;

endpackage

/* hw/cpu_isa_pkg.sv */
package cpu_isa_pkg;

  //////////////////////////////
  // field widths
  //////////////////////////////

  localparam int DATA_WIDTH    = 32;
  localparam int REG_ADDR_BITS = 5;
  localparam int IMM_BITS      = 16;
  localparam int OPCODE_BITS   = 6;
  localparam int SPARE_BITS    = DATA_WIDTH - OPCODE_BITS - 3 * REG_ADDR_BITS;

  //////////////////////////////
  // opcodes
  //////////////////////////////

  // all-zero word is a nop
  typedef enum logic [OPCODE_BITS-1:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_SLT  = 6'd5,
    OP_ADDI = 6'd6,
    OP_LW   = 6'd7,
    OP_SW   = 6'd8,
    OP_BEQ  = 6'd9,
    OP_BLT  = 6'd10,
    OP_J    = 6'd11
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_e;

  //////////////////////////////
  // instruction layout
  //////////////////////////////

  // rd and spare double as the 16 bit immediate
  typedef struct packed {
    opcode_e                  opcode;
    logic [REG_ADDR_BITS-1:0] rs;
    logic [REG_ADDR_BITS-1:0] rt;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [SPARE_BITS-1:0]    spare;
  } instr_t;

  function automatic logic [IMM_BITS-1:0] instr_imm(input instr_t instr);
    return instr[IMM_BITS-1:0];
  endfunction

endpackage
